/* all.f */
+incdir+verif
common/afu_pkg.sv
source/afu_reset_merge.sv
port_afu/port_req_decode.sv
port_afu/port_csr_engine.sv
port_afu/port_cpl_format.sv
port_afu/port_afu.sv
source/afu_main.sv
verif/tb_afu_main.sv

/* run_sim.sh */
#!/bin/sh
# Compiles the accelerator shell testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f all.f \
   --top-module tb_afu_main \
   -Mdir obj_dir \
   -o sim_afu
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit "$build_status"
fi

./obj_dir/sim_afu
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
   echo "Simulation failed with status $sim_status"
   exit "$sim_status"
fi

echo "Simulation finished with status 0"
exit 0

/* verif/tb_afu_tasks.svh */
//----------------------------------------------------------------------------
// Stimulus and directed test tasks, included inside the testbench module.
//----------------------------------------------------------------------------

`ifndef TB_AFU_TASKS_SVH
`define TB_AFU_TASKS_SVH

   // Starts and ends on a falling edge and keeps the word stable until taken
   task automatic send_req(int p, afu_pkg::afu_req_t req);
      issued_count++;
      sent_count[p]++;
      req_data[p]  = req;
      req_valid[p] = 1'b1;
      do begin
         @(posedge clk);
      end while (!req_ready[p]);
      exp_q[p].push_back(predict_cpl(p, req));
      acc_q[p].push_back($time);
      last_accept_t[p] = $time;
      @(negedge clk);
      req_valid[p] = 1'b0;
   endtask

   // Compares one completion with the oldest one the model predicted
   task automatic expect_cpl(int p);
      afu_pkg::afu_cpl_t exp_cpl;
      time               latency;
      check_true(exp_q[p].size() != 0,
                 $sformatf("Port %0d returned a completion with no request outstanding", p));
      exp_cpl = exp_q[p].pop_front();
      latency = ($time - acc_q[p].pop_front()) / CLK_PERIOD;
      check_equal($sformatf("cpl_data[%0d]", p), exp_cpl, cpl_data[p]);
      if (check_latency) begin
         check_equal($sformatf("cpl_valid[%0d] latency in cycles", p), 64'd3, 64'(latency));
      end
      done_count[p]++;
   endtask

   task automatic drain_pipeline();
      while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
         @(negedge clk);
      end
   endtask

   // No completion lost or duplicated on either port.
   // A few idle cycles give any extra completion time to reach the monitor
   task automatic check_counts();
      repeat (4) @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
         check_equal($sformatf("cpl_valid[%0d]", p), 64'd0, 64'(cpl_valid[p]));
         check_equal($sformatf("completion count of port %0d", p), 64'(sent_count[p]),
                     64'(done_count[p]));
      end
   endtask

   task automatic reset_reads();
      // Both ports open once their merged reset has been released
      while (req_ready != '1) begin
         @(negedge clk);
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
         check_equal($sformatf("cpl_valid[%0d]", p), 64'd0, 64'(cpl_valid[p]));
      end
      // Write data on a read is noise the port has to ignore
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int a = 0; a < afu_pkg::NUM_REGS; a++) begin
            send_req(p, make_req(OPC_READ, 8'($urandom), 4'(a), 32'($urandom)));
         end
      end
      drain_pipeline();
   endtask

   task automatic write_then_read();
      send_req(0, make_req(OPC_WRITE, 8'($urandom), 4'd5, 32'($urandom)));
      send_req(0, make_req(OPC_READ, 8'($urandom), 4'd5, 32'd0));
      send_req(1, make_req(OPC_READ, 8'($urandom), 4'd5, 32'd0));
      send_req(1, make_req(OPC_WRITE, 8'($urandom), 4'd12, 32'($urandom)));
      send_req(1, make_req(OPC_READ, 8'($urandom), 4'd12, 32'd0));
      send_req(0, make_req(OPC_READ, 8'($urandom), 4'd12, 32'd0));
      drain_pipeline();
   endtask

   task automatic unsupported_ops();
      for (int p = 0; p < NUM_PORTS; p++) begin
         send_req(p, make_req(OPC_WRITE, 8'($urandom), 4'd9, 32'($urandom)));
         send_req(p, make_req(2'd2, 8'($urandom), 4'd9, 32'($urandom)));
         send_req(p, make_req(2'd3, 8'($urandom), 4'd9, 32'($urandom)));
         send_req(p, make_req(OPC_READ, 8'($urandom), 4'd9, 32'd0));
      end
      drain_pipeline();
   endtask

   // Single request then a burst of writes each followed at once by its read
   task automatic latency_and_burst();
      time prev_t;
      cpl_ready     = '1;
      check_latency = 1'b1;
      send_req(0, make_req(OPC_READ, 8'($urandom), 4'd3, 32'd0));
      drain_pipeline();
      for (int i = 0; i < 8; i++) begin
         prev_t = last_accept_t[0];
         send_req(0, make_req((i % 2 == 0) ? OPC_WRITE : OPC_READ, 8'($urandom),
                              4'(i / 2), 32'($urandom)));
         if (i > 0) begin
            check_equal("req_ready[0] accept spacing in ns", 64'(CLK_PERIOD),
                        64'(last_accept_t[0] - prev_t));
         end
      end
      drain_pipeline();
      check_latency = 1'b0;
   endtask

   task automatic drive_random_port(int p, int count);
      afu_pkg::afu_req_t req;
      for (int i = 0; i < count; i++) begin
         repeat ($urandom_range(0, 3)) @(negedge clk);
         req = make_req(2'($urandom), 8'($urandom), 4'($urandom), 32'($urandom));
         // Reserved bits carry junk
         req[49:32] = 18'($urandom);
         send_req(p, req);
      end
      traffic_done++;
   endtask

   task automatic toggle_cpl_ready();
      while (traffic_done < NUM_PORTS) begin
         @(negedge clk);
         cpl_ready = 2'($urandom);
      end
      cpl_ready = '1;
   endtask

   task automatic random_traffic();
      traffic_done = 0;
      fork
         drive_random_port(0, 300);
         drive_random_port(1, 300);
         toggle_cpl_ready();
      join
      drain_pipeline();
      check_counts();
   endtask

   // Soft reset of port 1 must clear its registers and leave port 0 alone
   task automatic port_soft_reset();
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int a = 0; a < afu_pkg::NUM_REGS; a++) begin
            send_req(p, make_req(OPC_WRITE, 8'($urandom), 4'(a), 32'($urandom)));
         end
      end
      drain_pipeline();
      port_rst_n[1] = 1'b0;
      repeat (3) @(negedge clk);
      check_equal("req_ready[1]", 64'd0, 64'(req_ready[1]));
      check_equal("cpl_valid[1]", 64'd0, 64'(cpl_valid[1]));
      check_equal("req_ready[0]", 64'd1, 64'(req_ready[0]));
      port_rst_n[1] = 1'b1;
      clear_model(1);
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int a = 0; a < afu_pkg::NUM_REGS; a++) begin
            send_req(p, make_req(OPC_READ, 8'($urandom), 4'(a), 32'd0));
         end
      end
      drain_pipeline();
   endtask

`endif

/* verif/tb_afu_main.sv */
//----------------------------------------------------------------------------
// Testbench top for the accelerator shell with clock, reset, register model,
// completion scoreboard and watchdog. The directed tests come from the include.
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_afu_main;

   localparam int  NUM_PORTS  = 2;
   localparam time CLK_PERIOD = 20;

   // Request opcodes and completion status codes as the host sees them
   localparam logic [1:0] OPC_READ        = 2'd0;
   localparam logic [1:0] OPC_WRITE       = 2'd1;
   localparam logic [1:0] STS_UNSUPPORTED = 2'd1;

   logic                                 clk;
   logic                                 rst_n;
   logic              [NUM_PORTS-1:0]    port_rst_n;
   logic              [NUM_PORTS-1:0]    req_valid;
   logic              [NUM_PORTS-1:0]    req_ready;
   afu_pkg::afu_req_t [NUM_PORTS-1:0]    req_data;
   logic              [NUM_PORTS-1:0]    cpl_valid;
   logic              [NUM_PORTS-1:0]    cpl_ready;
   afu_pkg::afu_cpl_t [NUM_PORTS-1:0]    cpl_data;

   // Register model and the completions still owed by each port
   afu_pkg::afu_data_t model_regs [NUM_PORTS][afu_pkg::NUM_REGS];
   afu_pkg::afu_cpl_t  exp_q [NUM_PORTS][$];
   time                acc_q [NUM_PORTS][$];
   time                last_accept_t [NUM_PORTS];
   int                 sent_count [NUM_PORTS];
   int                 done_count [NUM_PORTS];

   int issued_count   = 0;
   int elapsed_cycles = 0;
   int traffic_done   = 0;
   bit check_latency  = 1'b0;

   afu_main #(
      .PG_NUM_PORTS (NUM_PORTS)
   ) i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .port_rst_n (port_rst_n),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_data   (req_data),
      .cpl_valid  (cpl_valid),
      .cpl_ready  (cpl_ready),
      .cpl_data   (cpl_data)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   //--------------------------------------------------------------------------
   // Checks
   //--------------------------------------------------------------------------

   task automatic check_equal(string name, logic [63:0] exp, logic [63:0] act);
      assert (act === exp) else begin
         $display("error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
         $display("*** FAILED ***");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_true(bit cond, string what);
      assert (cond) else begin
         $display("%s at %0d ns", what, $time);
         $display("*** FAILED ***");
         $fatal(1, "check failed");
      end
   endtask

   //--------------------------------------------------------------------------
   // Reference model
   //--------------------------------------------------------------------------

   function automatic afu_pkg::afu_req_t make_req(logic [1:0] op, afu_pkg::afu_tag_t tag,
                                                  afu_pkg::afu_addr_t addr,
                                                  afu_pkg::afu_data_t data);
      afu_pkg::afu_req_t req;
      req = '0;
      req[afu_pkg::REQ_OP_HI:afu_pkg::REQ_OP_LO]     = op;
      req[afu_pkg::REQ_TAG_HI:afu_pkg::REQ_TAG_LO]   = tag;
      req[afu_pkg::REQ_ADDR_HI:afu_pkg::REQ_ADDR_LO] = addr;
      req[afu_pkg::REQ_DATA_HI:afu_pkg::REQ_DATA_LO] = data;
      return req;
   endfunction

   // Requests of one port are served strictly in order, so applying them to
   // the model at acceptance gives every read the value the DUT must return
   function automatic afu_pkg::afu_cpl_t predict_cpl(int p, afu_pkg::afu_req_t req);
      logic [1:0]         op;
      afu_pkg::afu_addr_t addr;
      afu_pkg::afu_cpl_t  cpl;
      op   = req[afu_pkg::REQ_OP_HI:afu_pkg::REQ_OP_LO];
      addr = req[afu_pkg::REQ_ADDR_HI:afu_pkg::REQ_ADDR_LO];
      // Status ok is zero and data stays zero unless the request is a read
      cpl  = '0;
      cpl[afu_pkg::CPL_TAG_HI:afu_pkg::CPL_TAG_LO] =
         req[afu_pkg::REQ_TAG_HI:afu_pkg::REQ_TAG_LO];
      case (op)
         OPC_READ: begin
            cpl[afu_pkg::CPL_HAS_DATA] = 1'b1;
            cpl[afu_pkg::CPL_DATA_HI:afu_pkg::CPL_DATA_LO] = model_regs[p][addr];
         end
         OPC_WRITE: begin
            model_regs[p][addr] = req[afu_pkg::REQ_DATA_HI:afu_pkg::REQ_DATA_LO];
         end
         default: begin
            cpl[afu_pkg::CPL_STATUS_HI:afu_pkg::CPL_STATUS_LO] = STS_UNSUPPORTED;
         end
      endcase
      return cpl;
   endfunction

   task automatic clear_model(int p);
      for (int a = 0; a < afu_pkg::NUM_REGS; a++) begin
         model_regs[p][a] = '0;
      end
   endtask

`include "tb_afu_tasks.svh"

   //--------------------------------------------------------------------------
   // Completion monitor and watchdog
   //--------------------------------------------------------------------------

   // A completion moves on every rising edge where valid and ready are high
   always @(posedge clk) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (cpl_valid[p] && cpl_ready[p]) begin
            expect_cpl(p);
         end
      end
   end

   // Budget grows with every request issued so long tests get more time
   initial begin : watchdog
      while (elapsed_cycles <= 200 * issued_count + 1000) begin
         @(posedge clk);
         elapsed_cycles++;
      end
      $display("Timeout after %0d cycles with %0d requests issued", elapsed_cycles,
               issued_count);
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

   //--------------------------------------------------------------------------
   // Test sequence
   //--------------------------------------------------------------------------

   initial begin : main_sequence
      rst_n      = 1'b0;
      port_rst_n = '1;
      req_valid  = '0;
      req_data   = '0;
      cpl_ready  = '1;
      for (int p = 0; p < NUM_PORTS; p++) begin
         sent_count[p]    = 0;
         done_count[p]    = 0;
         last_accept_t[p] = 0;
         clear_model(p);
      end
      void'($urandom(78401));

      // Five cycles of power-on reset with both ports closed
      repeat (5) @(negedge clk);
      check_equal("req_ready", 64'd0, 64'(req_ready));
      check_equal("cpl_valid", 64'd0, 64'(cpl_valid));
      rst_n = 1'b1;

      reset_reads();
      write_then_read();
      unsupported_ops();
      latency_and_burst();
      random_traffic();
      port_soft_reset();
      check_counts();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* source/afu_main.sv */
//----------------------------------------------------------------------------
// User shell top level with one register accelerator per port.
// Each port runs on its own merged reset and its own request stream.
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module afu_main #(
   parameter int PG_NUM_PORTS = 2
) (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic              [PG_NUM_PORTS-1:0]       port_rst_n,

   // Request stream, one lane per port
   input  logic              [PG_NUM_PORTS-1:0]       req_valid,
   output logic              [PG_NUM_PORTS-1:0]       req_ready,
   input  afu_pkg::afu_req_t [PG_NUM_PORTS-1:0]       req_data,

   // Completion stream, one lane per port
   output logic              [PG_NUM_PORTS-1:0]       cpl_valid,
   input  logic              [PG_NUM_PORTS-1:0]       cpl_ready,
   output afu_pkg::afu_cpl_t [PG_NUM_PORTS-1:0]       cpl_data
);

   // Merged and synchronized reset for each port
   logic [PG_NUM_PORTS-1:0] port_rst_n_sync;

   //--------------------------------------------------------------------------
   // Reset merge
   //--------------------------------------------------------------------------

   afu_reset_merge #(
      .PG_NUM_PORTS (PG_NUM_PORTS)
   ) i_reset_merge (
      .clk             (clk),
      .rst_n           (rst_n),
      .port_rst_n      (port_rst_n),
      .port_rst_n_sync (port_rst_n_sync)
   );

   //--------------------------------------------------------------------------
   // Port accelerators
   //--------------------------------------------------------------------------

   for (genvar p = 0; p < PG_NUM_PORTS; p++) begin : g_port
      // Soft reset of one port leaves the others running
      port_afu i_port_afu (
         .clk       (clk),
         .rst_n     (port_rst_n_sync[p]),
         .req_valid (req_valid[p]),
         .req_ready (req_ready[p]),
         .req_data  (req_data[p]),
         .cpl_valid (cpl_valid[p]),
         .cpl_ready (cpl_ready[p]),
         .cpl_data  (cpl_data[p])
      );
   end

endmodule

/* port_afu/port_afu.sv */
//----------------------------------------------------------------------------
// Three-stage register access pipeline for one port.
// Decode, register file access and completion formatting, one cycle each.
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module port_afu (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req_valid,
   output logic              req_ready,
   input  afu_pkg::afu_req_t req_data,
   output logic              cpl_valid,
   input  logic              cpl_ready,
   output afu_pkg::afu_cpl_t cpl_data
);

   // Decode to engine
   logic                 dec_valid;
   logic                 dec_ready;
   afu_pkg::afu_op_e     dec_op;
   afu_pkg::afu_tag_t    dec_tag;
   afu_pkg::afu_addr_t   dec_addr;
   afu_pkg::afu_data_t   dec_wdata;

   // Engine to formatter
   logic                 eng_valid;
   logic                 eng_ready;
   afu_pkg::afu_status_e eng_status;
   afu_pkg::afu_tag_t    eng_tag;
   logic                 eng_has_data;
   afu_pkg::afu_data_t   eng_rdata;

   port_req_decode i_req_decode (
      .clk (clk), .rst_n (rst_n),
      .in_valid (req_valid), .in_ready (req_ready), .in_data (req_data),
      .out_valid (dec_valid), .out_ready (dec_ready), .out_op (dec_op),
      .out_tag (dec_tag), .out_addr (dec_addr), .out_wdata (dec_wdata)
   );

   port_csr_engine i_csr_engine (
      .clk (clk), .rst_n (rst_n),
      .in_valid (dec_valid), .in_ready (dec_ready), .in_op (dec_op),
      .in_tag (dec_tag), .in_addr (dec_addr), .in_wdata (dec_wdata),
      .out_valid (eng_valid), .out_ready (eng_ready), .out_status (eng_status),
      .out_tag (eng_tag), .out_has_data (eng_has_data), .out_rdata (eng_rdata)
   );

   port_cpl_format i_cpl_format (
      .clk (clk), .rst_n (rst_n),
      .in_valid (eng_valid), .in_ready (eng_ready), .in_status (eng_status),
      .in_tag (eng_tag), .in_has_data (eng_has_data), .in_rdata (eng_rdata),
      .out_valid (cpl_valid), .out_ready (cpl_ready), .out_data (cpl_data)
   );

endmodule

/* port_afu/port_cpl_format.sv */
//----------------------------------------------------------------------------
// Third pipeline stage. Packs status, tag and read data into the 64-bit
// completion word and holds it until the host side takes it.
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module port_cpl_format (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  afu_pkg::afu_status_e in_status,
   input  afu_pkg::afu_tag_t    in_tag,
   input  logic                 in_has_data,
   input  afu_pkg::afu_data_t   in_rdata,
   output logic                 out_valid,
   input  logic                 out_ready,
   output afu_pkg::afu_cpl_t    out_data
);

   logic              accept;
   afu_pkg::afu_cpl_t cpl_next;

   // Last stage, so its ready follows cpl_ready straight from the host
   assign in_ready = !out_valid || out_ready;
   assign accept   = in_valid && in_ready;

   //--------------------------------------------------------------------------
   // Completion packing
   //--------------------------------------------------------------------------

   always_comb begin
      // Unused bits 52..32 stay zero
      cpl_next = '0;
      cpl_next[afu_pkg::CPL_STATUS_HI:afu_pkg::CPL_STATUS_LO] = in_status;
      cpl_next[afu_pkg::CPL_TAG_HI:afu_pkg::CPL_TAG_LO]       = in_tag;
      cpl_next[afu_pkg::CPL_HAS_DATA]                         = in_has_data;
      // Writes and unsupported requests carry no data
      if (in_has_data) begin
         cpl_next[afu_pkg::CPL_DATA_HI:afu_pkg::CPL_DATA_LO] = in_rdata;
      end
   end

   //--------------------------------------------------------------------------
   // Output register
   //--------------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (accept) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_data <= cpl_next;
      end
   end

endmodule

/* port_afu/port_csr_engine.sv */
//----------------------------------------------------------------------------
// Second pipeline stage. Owns the 16-entry scratch register file and runs
// each decoded read or write against it as the request enters the stage.
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module port_csr_engine (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  afu_pkg::afu_op_e     in_op,
   input  afu_pkg::afu_tag_t    in_tag,
   input  afu_pkg::afu_addr_t   in_addr,
   input  afu_pkg::afu_data_t   in_wdata,
   output logic                 out_valid,
   input  logic                 out_ready,
   output afu_pkg::afu_status_e out_status,
   output afu_pkg::afu_tag_t    out_tag,
   output logic                 out_has_data,
   output afu_pkg::afu_data_t   out_rdata
);

   // Scratch registers, visible to the host through reads and writes
   afu_pkg::afu_data_t regs [afu_pkg::NUM_REGS];

   logic accept;
   logic is_read;
   logic is_write;

   assign in_ready = !out_valid || out_ready;
   assign accept   = in_valid && in_ready;

   // Decode has already folded every other code into OP_UNSUPPORTED
   assign is_read  = (in_op == afu_pkg::OP_READ);
   assign is_write = (in_op == afu_pkg::OP_WRITE);

   //--------------------------------------------------------------------------
   // Register file
   //--------------------------------------------------------------------------

   // A write lands on the same edge that moves it into the output register.
   // A read in the following request therefore sees the new value
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < afu_pkg::NUM_REGS; i++) begin
            regs[i] <= afu_pkg::REG_RESET_VALUE;
         end
      end else if (accept && is_write) begin
         regs[in_addr] <= in_wdata;
      end
   end

   //--------------------------------------------------------------------------
   // Stage register
   //--------------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (accept) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // Response fields of the request now held in this stage
   always_ff @(posedge clk) begin
      if (accept) begin
         out_tag      <= in_tag;
         out_has_data <= is_read;
         // Reads see the value before any write on this same edge,
         // which can only belong to this request and never to a read
         out_rdata    <= regs[in_addr];
         if (is_read || is_write) begin
            out_status <= afu_pkg::ST_OK;
         end else begin
            out_status <= afu_pkg::ST_UNSUPPORTED;
         end
      end
   end

endmodule

/* port_afu/port_req_decode.sv */
//----------------------------------------------------------------------------
// First pipeline stage. Registers a request word and splits it into fields,
// folding unknown opcodes into one unsupported code.
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module port_req_decode (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   output logic               in_ready,
   input  afu_pkg::afu_req_t  in_data,
   output logic               out_valid,
   input  logic               out_ready,
   output afu_pkg::afu_op_e   out_op,
   output afu_pkg::afu_tag_t  out_tag,
   output afu_pkg::afu_addr_t out_addr,
   output afu_pkg::afu_data_t out_wdata
);

   // Set one edge after reset release, keeps the port closed while in reset
   logic             run_q;
   logic             accept;
   logic [1:0]       raw_op;
   afu_pkg::afu_op_e op_next;

   // Stage takes a word when empty or when its current word leaves this cycle
   assign in_ready = run_q && (!out_valid || out_ready);
   assign accept   = in_valid && in_ready;

   //--------------------------------------------------------------------------
   // Opcode folding
   //--------------------------------------------------------------------------

   assign raw_op = in_data[afu_pkg::REQ_OP_HI:afu_pkg::REQ_OP_LO];

   always_comb begin
      case (raw_op)
         2'd0:    op_next = afu_pkg::OP_READ;
         2'd1:    op_next = afu_pkg::OP_WRITE;
         default: op_next = afu_pkg::OP_UNSUPPORTED;
      endcase
   end

   //--------------------------------------------------------------------------
   // Stage register
   //--------------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run_q     <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         run_q <= 1'b1;
         if (accept) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   // Fields only, the valid flag above says whether they mean anything
   always_ff @(posedge clk) begin
      if (accept) begin
         out_op    <= op_next;
         out_tag   <= in_data[afu_pkg::REQ_TAG_HI:afu_pkg::REQ_TAG_LO];
         out_addr  <= in_data[afu_pkg::REQ_ADDR_HI:afu_pkg::REQ_ADDR_LO];
         out_wdata <= in_data[afu_pkg::REQ_DATA_HI:afu_pkg::REQ_DATA_LO];
      end
   end

endmodule

/* source/afu_reset_merge.sv */
//----------------------------------------------------------------------------
// Combines power-on reset with each port's soft reset.
// Assertion from rst_n is immediate, release is synchronized to clk.
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module afu_reset_merge #(
   parameter int PG_NUM_PORTS = 2
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [PG_NUM_PORTS-1:0] port_rst_n,
   output logic [PG_NUM_PORTS-1:0] port_rst_n_sync
);

   // First and second flop of each port's chain
   logic [PG_NUM_PORTS-1:0] meta_q;
   logic [PG_NUM_PORTS-1:0] sync_q;

   //--------------------------------------------------------------------------
   // One two-flop chain per port
   //--------------------------------------------------------------------------

   for (genvar p = 0; p < PG_NUM_PORTS; p++) begin : g_port
      // Power-on reset clears the chain at once, so the merged reset
      // follows rst_n going low without waiting for a clock
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            meta_q[p] <= 1'b0;
            sync_q[p] <= 1'b0;
         end else begin
            // A low soft reset shifts in and reaches the output two edges later
            meta_q[p] <= port_rst_n[p];
            sync_q[p] <= meta_q[p];
         end
      end
   end

   // Release takes two rising edges after both inputs are high
   assign port_rst_n_sync = sync_q;

endmodule

/* common/afu_pkg.sv */
//----------------------------------------------------------------------------
// Word types, field positions and codes shared by the accelerator shell.
// Modules reference these by scoped name, there is no import.
//----------------------------------------------------------------------------

package afu_pkg;

   // Whole words moving on the request and completion streams
   typedef logic [63:0] afu_req_t;
   typedef logic [63:0] afu_cpl_t;

   // Tag is echoed back to the host without change
   typedef logic [7:0]  afu_tag_t;
   typedef logic [3:0]  afu_addr_t;
   typedef logic [31:0] afu_data_t;

   // Any opcode other than read or write is folded into OP_UNSUPPORTED by decode
   typedef enum logic [1:0] {
      OP_READ        = 2'd0,
      OP_WRITE       = 2'd1,
      OP_UNSUPPORTED = 2'd2
   } afu_op_e;

   typedef enum logic [1:0] {
      ST_OK          = 2'd0,
      ST_UNSUPPORTED = 2'd1
   } afu_status_e;

   // Scratch register file
   localparam int NUM_REGS = 16;
   localparam afu_data_t REG_RESET_VALUE = '0;

   // Request layout, bits 49..32 are reserved and ignored
   localparam int REQ_OP_HI   = 63;
   localparam int REQ_OP_LO   = 62;
   localparam int REQ_TAG_HI  = 61;
   localparam int REQ_TAG_LO  = 54;
   localparam int REQ_ADDR_HI = 53;
   localparam int REQ_ADDR_LO = 50;
   localparam int REQ_DATA_HI = 31;
   localparam int REQ_DATA_LO = 0;

   // Completion layout, bits 52..32 are always zero
   localparam int CPL_STATUS_HI = 63;
   localparam int CPL_STATUS_LO = 62;
   localparam int CPL_TAG_HI    = 61;
   localparam int CPL_TAG_LO    = 54;
   localparam int CPL_HAS_DATA  = 53;
   localparam int CPL_DATA_HI   = 31;
   localparam int CPL_DATA_LO   = 0;

endpackage
